//--- src/componentCount_settings.svh
`ifndef COMPONENTCOUNT_SETTINGS_SVH
`define COMPONENTCOUNT_SETTINGS_SVH

// Chain graph size and first-level group size
`define GRAPH_WIDTH 64
`define GROUP_WIDTH 4

// Stage latencies inside the ring
`define SEED_DEPTH 3
`define EXPLORE_DEPTH 4

// Entry register plus both stage blocks
`define RING_DEPTH (1 + `SEED_DEPTH + `EXPLORE_DEPTH)

`define TAG_WIDTH 8
`define COUNT_WIDTH 6

`endif

//--- src/componentCountPkg.sv
`default_nettype none

`include "componentCount_settings.svh"

package componentCountPkg;

    // One bit per chain node
    typedef logic [`GRAPH_WIDTH-1:0] graphT;

    typedef logic [`TAG_WIDTH-1:0] tagT;
    typedef logic [`COUNT_WIDTH-1:0] countT;

    typedef enum logic {
        slotFree = 1'b0,
        slotBusy = 1'b1
    } slotPhaseE;

    // Travels around the ring beside the graph
    typedef struct packed {
        slotPhaseE phase;
        countT     count;
        tagT       tag;
    } slotTokenT;

endpackage

`default_nettype wire

//--- src/delayLine.sv
`default_nettype none

`include "componentCount_settings.svh"

module delayLine #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);

    logic [WIDTH-1:0] stages [CYCLES];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < CYCLES; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= d;
            for (int i = 1; i < CYCLES; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign q = stages[CYCLES-1];

endmodule

`default_nettype wire

//--- src/firstBitFinder.sv
`default_nettype none

`include "componentCount_settings.svh"

module firstBitFinder import componentCountPkg::*; (
    input  logic                                clk,
    input  logic                                rstN,
    input  graphT                               graph,
    output logic [`GRAPH_WIDTH/`GROUP_WIDTH-1:0] firstGroup,
    output logic                                isEmpty
);

    localparam int GW = `GROUP_WIDTH;
    localparam int NUM_GROUPS = `GRAPH_WIDTH / `GROUP_WIDTH;
    // A 16-bit block is GW groups of GW bits
    localparam int NUM_BLOCKS = NUM_GROUPS / GW;

    logic [NUM_GROUPS-1:0] hasBit4;
    logic [NUM_BLOCKS-1:0] hasBit16;
    logic [NUM_BLOCKS:0] noEarlier16;
    logic [NUM_GROUPS-1:0] firstGroupNext;

    // Stage 1
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hasBit4 <= '0;
        end else begin
            for (int g = 0; g < NUM_GROUPS; g++) begin
                hasBit4[g] <= |graph[g*GW +: GW];
            end
        end
    end

    // Stage 2, block flags and prefix chain
    always_comb begin
        logic lowerClear;
        noEarlier16[0] = 1'b1;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            hasBit16[b] = |hasBit4[b*GW +: GW];
            noEarlier16[b+1] = noEarlier16[b] && !hasBit16[b];
            lowerClear = noEarlier16[b];
            for (int k = 0; k < GW; k++) begin
                firstGroupNext[b*GW+k] = lowerClear;
                lowerClear = lowerClear && !hasBit4[b*GW+k];
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            firstGroup <= '0;
            isEmpty <= 1'b1;
        end else begin
            firstGroup <= firstGroupNext;
            isEmpty <= noEarlier16[NUM_BLOCKS];
        end
    end

endmodule

`default_nettype wire

//--- src/seedSelector.sv
`default_nettype none

`include "componentCount_settings.svh"

module seedSelector import componentCountPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  graphT     graphIn,
    input  slotTokenT tokenIn,
    output graphT     graphOut,
    output graphT     seed,
    output slotTokenT tokenOut
);

    localparam int GW = `GROUP_WIDTH;
    localparam int NUM_GROUPS = `GRAPH_WIDTH / `GROUP_WIDTH;
    localparam int FINDER_DEPTH = `SEED_DEPTH - 1;

    logic [NUM_GROUPS-1:0] firstGroup;
    logic isEmpty;
    graphT graphD;
    slotTokenT tokenD;
    graphT seedNext;
    slotTokenT tokenNext;

    firstBitFinder i_firstBitFinder (
        .clk(clk),
        .rstN(rstN),
        .graph(graphIn),
        .firstGroup(firstGroup),
        .isEmpty(isEmpty)
    );

    // Side data waits for the finder
    delayLine #(.CYCLES(FINDER_DEPTH), .WIDTH(`GRAPH_WIDTH)) i_graphDelay (
        .clk(clk),
        .rstN(rstN),
        .d(graphIn),
        .q(graphD)
    );

    delayLine #(.CYCLES(FINDER_DEPTH), .WIDTH($bits(slotTokenT))) i_tokenDelay (
        .clk(clk),
        .rstN(rstN),
        .d(tokenIn),
        .q(tokenD)
    );

    // Lowest set bit of the first marked group
    always_comb begin
        logic taken;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            taken = 1'b0;
            for (int k = 0; k < GW; k++) begin
                seedNext[g*GW+k] = firstGroup[g] && graphD[g*GW+k] && !taken;
                taken = taken || graphD[g*GW+k];
            end
        end
        tokenNext = tokenD;
        if (tokenD.phase == slotBusy && !isEmpty) begin
            tokenNext.count = tokenD.count + countT'(1);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            graphOut <= '0;
            seed <= '0;
            tokenOut <= '0;
        end else begin
            graphOut <= graphD;
            seed <= seedNext;
            tokenOut <= tokenNext;
        end
    end

    // At most one seed, and one whenever the graph still has nodes
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(seed) && ((|seed) == (|graphOut)));

endmodule

`default_nettype wire

//--- src/runExplorer.sv
`default_nettype none

`include "componentCount_settings.svh"

module runExplorer import componentCountPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  graphT     graph,
    input  graphT     seed,
    input  slotTokenT tokenIn,
    output graphT     reduced,
    output logic      runEnd,
    output slotTokenT tokenOut
);

    localparam int GW = `GROUP_WIDTH;
    localparam int NUM_GROUPS = `GRAPH_WIDTH / `GROUP_WIDTH;
    localparam int NUM_BLOCKS = NUM_GROUPS / GW;
    localparam int RUN_DEPTH = `EXPLORE_DEPTH - 1;

    graphT localRunN, prefixOnesN, localRun1, prefixOnes1, localRun2, prefixOnes2;
    logic [NUM_GROUPS-1:0] groupCarryN, groupFullN, groupCarry1, groupFull1;
    logic [NUM_GROUPS-1:0] cinBlkN, fullBelowN, cinBlk2, fullBelow2;
    logic [NUM_BLOCKS-1:0] blkCarryN, blkFullN, blkCarry2, blkFull2;
    graphT runN, run3, graphS3, reducedNext;

    delayLine #(.CYCLES(RUN_DEPTH), .WIDTH(`GRAPH_WIDTH)) i_graphDelay (
        .clk(clk), .rstN(rstN), .d(graph), .q(graphS3)
    );

    delayLine #(.CYCLES(`EXPLORE_DEPTH), .WIDTH($bits(slotTokenT))) i_tokenDelay (
        .clk(clk), .rstN(rstN), .d(tokenIn), .q(tokenOut)
    );

    // Stage 1, seed climbs inside each group
    always_comb begin
        logic chain;
        logic ones;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            chain = 1'b0;
            ones = 1'b1;
            for (int k = 0; k < GW; k++) begin
                chain = graph[g*GW+k] && (seed[g*GW+k] || chain);
                ones = ones && graph[g*GW+k];
                localRunN[g*GW+k] = chain;
                prefixOnesN[g*GW+k] = ones;
            end
            groupCarryN[g] = chain;
            groupFullN[g] = ones;
        end
    end

    // Stage 2, carry over groups inside each 4-group block
    always_comb begin
        logic cin;
        logic below;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            cin = 1'b0;
            below = 1'b1;
            for (int j = 0; j < GW; j++) begin
                cinBlkN[b*GW+j] = cin;
                fullBelowN[b*GW+j] = below;
                cin = groupCarry1[b*GW+j] || (cin && groupFull1[b*GW+j]);
                below = below && groupFull1[b*GW+j];
            end
            blkCarryN[b] = cin;
            blkFullN[b] = below;
        end
    end

    // Stage 3, carry over blocks, then fill the entered groups from the bottom
    always_comb begin
        logic bcin;
        logic gcin;
        bcin = 1'b0;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int j = 0; j < GW; j++) begin
                gcin = cinBlk2[b*GW+j] || (bcin && fullBelow2[b*GW+j]);
                runN[(b*GW+j)*GW +: GW] = localRun2[(b*GW+j)*GW +: GW]
                    | (prefixOnes2[(b*GW+j)*GW +: GW] & {GW{gcin}});
            end
            bcin = blkCarry2[b] || (bcin && blkFull2[b]);
        end
    end

    assign reducedNext = graphS3 & ~run3;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {localRun1, prefixOnes1, groupCarry1, groupFull1} <= '0;
            {localRun2, prefixOnes2, cinBlk2, fullBelow2, blkCarry2, blkFull2} <= '0;
            run3 <= '0;
            reduced <= '0;
            runEnd <= 1'b1;
        end else begin
            {localRun1, prefixOnes1, groupCarry1, groupFull1}
                <= {localRunN, prefixOnesN, groupCarryN, groupFullN};
            {localRun2, prefixOnes2, cinBlk2, fullBelow2, blkCarry2, blkFull2}
                <= {localRun1, prefixOnes1, cinBlkN, fullBelowN, blkCarryN, blkFullN};
            run3 <= runN;
            reduced <= reducedNext;
            // Nothing left to take and nothing taken this trip
            runEnd <= !(|run3) && !(|reducedNext);
        end
    end

    // Run lies inside the graph, and exists exactly when a seed entered
    assert property (@(posedge clk) disable iff (!rstN)
        ((run3 & ~graphS3) == '0) && ((|run3) == $past(|seed, RUN_DEPTH)));

endmodule

`default_nettype wire

//--- src/componentCounter.sv
`default_nettype none

`include "componentCount_settings.svh"

module componentCounter import componentCountPkg::*; (
    input  logic  clk,
    input  logic  rstN,
    output logic  request,
    input  graphT graphIn,
    input  logic  graphInValid,
    input  tagT   tagIn,
    output logic  done,
    output countT countOut,
    output tagT   tagOut
);

    localparam int COUNT_LIMIT = `GRAPH_WIDTH / 2;

    graphT entryGraph;
    slotTokenT entryToken;
    graphT selGraph;
    graphT selSeed;
    slotTokenT selToken;
    graphT reduced;
    logic runEnd;
    slotTokenT retToken;
    logic ringLive;

    // Low while in reset, high from the first clock after it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ringLive <= 1'b0;
        end else begin
            ringLive <= 1'b1;
        end
    end

    // Slot returning now is free or has finished
    assign request = ringLive && (retToken.phase == slotFree || runEnd);

    // Entry register closes the ring
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            entryGraph <= '0;
            entryToken <= '0;
        end else if (request) begin
            entryGraph <= graphInValid ? graphIn : '0;
            entryToken.phase <= graphInValid ? slotBusy : slotFree;
            entryToken.count <= '0;
            entryToken.tag <= tagIn;
        end else begin
            entryGraph <= reduced;
            entryToken <= retToken;
        end
    end

    seedSelector i_seedSelector (
        .clk(clk),
        .rstN(rstN),
        .graphIn(entryGraph),
        .tokenIn(entryToken),
        .graphOut(selGraph),
        .seed(selSeed),
        .tokenOut(selToken)
    );

    runExplorer i_runExplorer (
        .clk(clk),
        .rstN(rstN),
        .graph(selGraph),
        .seed(selSeed),
        .tokenIn(selToken),
        .reduced(reduced),
        .runEnd(runEnd),
        .tokenOut(retToken)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            done <= 1'b0;
        end else begin
            done <= (retToken.phase == slotBusy) && runEnd;
        end
    end

    // Result payload, qualified by done
    always_ff @(posedge clk) begin
        countOut <= retToken.count;
        tagOut <= retToken.tag;
    end

    // A finishing slot sat busy in the entry register one ring trip earlier
    assert property (@(posedge clk) disable iff (!rstN)
        done |-> $past(entryToken.phase, `RING_DEPTH) == slotBusy);

    assert property (@(posedge clk) !rstN |-> !request && !done);

    assert property (@(posedge clk) disable iff (!rstN)
        done |-> countOut <= COUNT_LIMIT);

    // An admitted graph is back at the entry one ring trip later, still busy
    assert property (@(posedge clk) disable iff (!rstN)
        request && graphInValid |-> ##(`RING_DEPTH)
            (retToken.phase == slotBusy) && (retToken.tag == $past(tagIn, `RING_DEPTH)));

endmodule

`default_nettype wire

//--- tests/componentCounterTb.sv
`default_nettype none

`include "componentCount_settings.svh"

module componentCounterTb import componentCountPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_GRAPHS = 120;
    localparam int NUM_BOUNDARY = 4;
    localparam int NUM_TAGS = 1 << `TAG_WIDTH;
    // k runs take k+1 trips, at most 33 for a 64-node chain
    localparam int TRIP_LIMIT = `GRAPH_WIDTH / 2 + 1;
    localparam int DRAIN_CYCLES = TRIP_LIMIT * `RING_DEPTH + `RING_DEPTH;
    localparam longint WATCHDOG_NS = longint'(NUM_GRAPHS) * TRIP_LIMIT * `RING_DEPTH * 20 + 20000;

    localparam int T_RESET = 0;
    localparam int T_BOUNDARY = 1;
    localparam int T_RANDOM = 2;
    localparam int T_TAGS = 3;
    localparam int T_INVALID = 4;

    logic clk;
    logic rstN;
    logic request;
    graphT graphIn;
    logic graphInValid;
    tagT tagIn;
    logic done;
    countT countOut;
    tagT tagOut;

    integer seed = 32'h4642;
    string testNames [5] = '{"resetRequest", "boundary", "random", "tagAccounting", "invalidOffer"};
    int testErrors [5];
    int returned [5];
    int planned [5];
    // Expected results, indexed by tag
    int expCount [NUM_TAGS];
    int tagTest [NUM_TAGS];
    bit pending [NUM_TAGS];
    int issued;
    int outstanding;
    int cycle;
    int invalidCount;
    int retryAt [$];
    graphT nextGraph;
    int nextExp;
    int nextTest;

    componentCounter i_componentCounter (
        .clk(clk),
        .rstN(rstN),
        .request(request),
        .graphIn(graphIn),
        .graphInValid(graphInValid),
        .tagIn(tagIn),
        .done(done),
        .countOut(countOut),
        .tagOut(tagOut)
    );

    always #10 clk = ~clk;

    // Number of runs of ones along the chain
    function automatic int countRuns(graphT g);
        int runs;
        logic prev;
        runs = 0;
        prev = 1'b0;
        for (int i = 0; i < `GRAPH_WIDTH; i++) begin
            if (g[i] && !prev) begin
                runs++;
            end
            prev = g[i];
        end
        return runs;
    endfunction

    task automatic compareValue(input int testId, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0d, actual %0d", testNames[testId], expected, actual);
            testErrors[testId]++;
        end
    endtask

    task automatic reportProblem(input int testId, input string msg);
        $display("Error in %s: %s", testNames[testId], msg);
        testErrors[testId]++;
    endtask

    task automatic finishTest(input int testId);
        $display("Test %s finished with %0d errors", testNames[testId], testErrors[testId]);
    endtask

    task automatic makeGraph(input int index, output graphT g, output int expected,
                             output int testId);
        int kind;
        int lo;
        int len;
        testId = T_BOUNDARY;
        // Fixed corner cases first, with counts known by hand
        case (index)
            0: begin g = '0; expected = 0; end
            1: begin g = '1; expected = 1; end
            2: begin g = {(`GRAPH_WIDTH/2){2'b01}}; expected = `GRAPH_WIDTH / 2; end
            3: begin g = {(`GRAPH_WIDTH/2){2'b10}}; expected = `GRAPH_WIDTH / 2; end
            default: begin
                testId = T_RANDOM;
                kind = $unsigned($random(seed)) % 8;
                case (kind)
                    0: g = '0;
                    1: g = '1;
                    2: g = {(`GRAPH_WIDTH/2){2'b01}} << ($unsigned($random(seed)) % 2);
                    3: begin
                        lo = $unsigned($random(seed)) % `GRAPH_WIDTH;
                        len = 1 + $unsigned($random(seed)) % `GRAPH_WIDTH;
                        g = '0;
                        for (int i = lo; i < lo + len && i < `GRAPH_WIDTH; i++) begin
                            g[i] = 1'b1;
                        end
                    end
                    4: g = {$random(seed), $random(seed)} & {$random(seed), $random(seed)};
                    default: g = {$random(seed), $random(seed)};
                endcase
                expected = countRuns(g);
            end
        endcase
    endtask

    // One falling edge: check results, then answer a request
    task automatic serviceCycle();
        int t;
        cycle++;
        if (done) begin
            t = int'(tagOut);
            if (!pending[t]) begin
                reportProblem(T_TAGS, $sformatf("unexpected tag %0d", t));
            end else begin
                compareValue(tagTest[t], expCount[t], int'(countOut));
                pending[t] = 1'b0;
                outstanding--;
                returned[tagTest[t]]++;
                if (returned[tagTest[t]] == planned[tagTest[t]]) begin
                    finishTest(tagTest[t]);
                end
            end
        end
        if (cycle <= `RING_DEPTH) begin
            compareValue(T_RESET, 1, int'(request));
            compareValue(T_RESET, 0, int'(done));
            if (cycle == `RING_DEPTH) begin
                finishTest(T_RESET);
            end
        end
        // A refused slot comes back free one trip later
        if (retryAt.size() > 0 && retryAt[0] == cycle) begin
            void'(retryAt.pop_front());
            compareValue(T_INVALID, 1, int'(request));
        end
        graphInValid = 1'b0;
        if (request) begin
            if (issued < NUM_GRAPHS && ($unsigned($random(seed)) % 8) != 0) begin
                graphIn = nextGraph;
                graphInValid = 1'b1;
                tagIn = tagT'(issued);
                pending[issued] = 1'b1;
                expCount[issued] = nextExp;
                tagTest[issued] = nextTest;
                issued++;
                outstanding++;
                if (issued < NUM_GRAPHS) begin
                    makeGraph(issued, nextGraph, nextExp, nextTest);
                end
            end else begin
                graphIn = {$random(seed), $random(seed)};
                tagIn = tagT'($random(seed));
                retryAt.push_back(cycle + `RING_DEPTH);
                if (issued < NUM_GRAPHS) begin
                    invalidCount++;
                end
            end
        end
    endtask

    initial begin
        int drain;
        int totalErrors;
        clk = 1'b0;
        rstN = 1'b0;
        graphIn = '0;
        graphInValid = 1'b0;
        tagIn = '0;
        issued = 0;
        outstanding = 0;
        cycle = 0;
        invalidCount = 0;
        planned[T_BOUNDARY] = NUM_BOUNDARY;
        planned[T_RANDOM] = NUM_GRAPHS - NUM_BOUNDARY;
        makeGraph(0, nextGraph, nextExp, nextTest);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        while (issued < NUM_GRAPHS) begin
            @(negedge clk);
            serviceCycle();
        end
        drain = 0;
        while (outstanding > 0 && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            serviceCycle();
            drain++;
        end
        // Extra trips to catch a stray done
        repeat (2 * `RING_DEPTH) begin
            @(negedge clk);
            serviceCycle();
        end
        for (int t = 0; t < issued; t++) begin
            if (pending[t]) begin
                reportProblem(T_TAGS, $sformatf("missing result for tag %0d", t));
            end
        end
        compareValue(T_INVALID, 1, int'(invalidCount > 0));
        finishTest(T_TAGS);
        finishTest(T_INVALID);
        totalErrors = 0;
        for (int i = 0; i < 5; i++) begin
            totalErrors += testErrors[i];
        end
        $display("Tests 5, graphs %0d, invalid offers %0d, errors %0d",
                 issued, invalidCount, totalErrors);
        if (totalErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all results came back");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/componentCountPkg.sv
src/delayLine.sv
src/firstBitFinder.sv
src/seedSelector.sv
src/runExplorer.sv
src/componentCounter.sv
tests/componentCounterTb.sv

//--- run.sh
#!/bin/sh
# Build and run the component counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module componentCounterTb -f vlog.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VcomponentCounterTb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
